// File: hw/rv_core_pkg.sv
/* shared widths, opcodes and enums for the byte-bus RV32I subset core
   only the low 17 address bits reach real memory */
`default_nettype none

package rv_core_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [7:0]  byte_t;
  typedef logic [4:0]  reg_idx_t;

  // low 3 bits follow RV32I funct3, bit 3 marks the funct7 alternate
  // (branches reuse the encoding to carry their own funct3)
  typedef enum logic [3:0] {
    ALU_ADD    = 4'b0000,
    ALU_SLL    = 4'b0001,
    ALU_SLT    = 4'b0010,
    ALU_SLTU   = 4'b0011,
    ALU_XOR    = 4'b0100,
    ALU_SRL    = 4'b0101,
    ALU_OR     = 4'b0110,
    ALU_AND    = 4'b0111,
    ALU_SUB    = 4'b1000,
    ALU_SRA    = 4'b1101,
    ALU_PASS_B = 4'b1111
  } alu_op_e;

  typedef enum logic [2:0] {
    CLS_ALU_REG, CLS_ALU_IMM, CLS_LUI, CLS_BRANCH, CLS_JAL, CLS_LOAD, CLS_STORE, CLS_NOP
  } instr_class_e;

  typedef enum logic [1:0] {
    SEQ_FETCH, SEQ_EXECUTE, SEQ_MEMORY, SEQ_RESULT
  } seq_state_e;

  localparam logic [6:0] OPC_REG    = 7'b0110011;
  localparam logic [6:0] OPC_IMM    = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;

  localparam addr_t RESET_PC = 32'h0000_0000;

endpackage

`default_nettype wire

// File: hw/rv_decode.sv
/* combinational decoder, anything outside the kept subset becomes a nop
   loads and stores decode only in their word form */
`timescale 1ns/1ps
`default_nettype none

module rv_decode (
  input  rv_core_pkg::word_t        instr,
  output rv_core_pkg::reg_idx_t     rs1,
  output rv_core_pkg::reg_idx_t     rs2,
  output rv_core_pkg::reg_idx_t     rd,
  output rv_core_pkg::word_t        imm,
  output rv_core_pkg::alu_op_e      alu_op,
  output rv_core_pkg::instr_class_e instr_class
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign rd     = instr[11:7];

  always_comb begin
    instr_class = rv_core_pkg::CLS_NOP;
    alu_op      = rv_core_pkg::ALU_ADD;
    imm         = '0;
    case (opcode)
      rv_core_pkg::OPC_REG: begin
        instr_class = rv_core_pkg::CLS_ALU_REG;
        case ({funct7, funct3})
          {7'h00, 3'b000}: alu_op = rv_core_pkg::ALU_ADD;
          {7'h20, 3'b000}: alu_op = rv_core_pkg::ALU_SUB;
          {7'h00, 3'b001}: alu_op = rv_core_pkg::ALU_SLL;
          {7'h00, 3'b010}: alu_op = rv_core_pkg::ALU_SLT;
          {7'h00, 3'b011}: alu_op = rv_core_pkg::ALU_SLTU;
          {7'h00, 3'b100}: alu_op = rv_core_pkg::ALU_XOR;
          {7'h00, 3'b101}: alu_op = rv_core_pkg::ALU_SRL;
          {7'h20, 3'b101}: alu_op = rv_core_pkg::ALU_SRA;
          {7'h00, 3'b110}: alu_op = rv_core_pkg::ALU_OR;
          {7'h00, 3'b111}: alu_op = rv_core_pkg::ALU_AND;
          default:         instr_class = rv_core_pkg::CLS_NOP;
        endcase
      end
      rv_core_pkg::OPC_IMM: begin
        instr_class = rv_core_pkg::CLS_ALU_IMM;
        imm = {{20{instr[31]}}, instr[31:20]};
        case (funct3)
          3'b000:  alu_op = rv_core_pkg::ALU_ADD;
          3'b010:  alu_op = rv_core_pkg::ALU_SLT;
          3'b011:  alu_op = rv_core_pkg::ALU_SLTU;
          3'b100:  alu_op = rv_core_pkg::ALU_XOR;
          3'b110:  alu_op = rv_core_pkg::ALU_OR;
          3'b111:  alu_op = rv_core_pkg::ALU_AND;
          3'b001:  begin
            alu_op = rv_core_pkg::ALU_SLL;
            if (funct7 != 7'h00) instr_class = rv_core_pkg::CLS_NOP;
          end
          default: begin
            // srli / srai share funct3, funct7 picks the fill
            if (funct7 == 7'h00) alu_op = rv_core_pkg::ALU_SRL;
            else if (funct7 == 7'h20) alu_op = rv_core_pkg::ALU_SRA;
            else instr_class = rv_core_pkg::CLS_NOP;
          end
        endcase
      end
      rv_core_pkg::OPC_LUI: begin
        instr_class = rv_core_pkg::CLS_LUI;
        alu_op      = rv_core_pkg::ALU_PASS_B;
        imm         = {instr[31:12], 12'b0};
      end
      rv_core_pkg::OPC_BRANCH: begin
        // funct3 rides to execute inside alu_op
        if (funct3[2:1] != 2'b01) instr_class = rv_core_pkg::CLS_BRANCH;
        alu_op = rv_core_pkg::alu_op_e'({1'b0, funct3});
        imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
      end
      rv_core_pkg::OPC_JAL: begin
        instr_class = rv_core_pkg::CLS_JAL;
        imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
      end
      rv_core_pkg::OPC_LOAD: begin
        if (funct3 == 3'b010) instr_class = rv_core_pkg::CLS_LOAD;
        imm = {{20{instr[31]}}, instr[31:20]};
      end
      rv_core_pkg::OPC_STORE: begin
        if (funct3 == 3'b010) instr_class = rv_core_pkg::CLS_STORE;
        imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      end
      default: instr_class = rv_core_pkg::CLS_NOP;
    endcase
  end

endmodule

`default_nettype wire

// File: hw/rv_reg_file.sv
/* x1..x31 with async clear, x0 reads zero; reads are combinational
   and a write lands at the next rising edge unless rdy_in is low */
`timescale 1ns/1ps
`default_nettype none

module rv_reg_file (
  input  logic                  clk_in,
  input  logic                  rst_n,
  input  logic                  rdy_in,
  input  rv_core_pkg::reg_idx_t rs1,
  input  rv_core_pkg::reg_idx_t rs2,
  output rv_core_pkg::word_t    rs1_val,
  output rv_core_pkg::word_t    rs2_val,
  input  logic                  wr_en,
  input  rv_core_pkg::reg_idx_t wr_idx,
  input  rv_core_pkg::word_t    wr_data
);

  rv_core_pkg::word_t regs [1:31];

  always_ff @(posedge clk_in or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (rdy_in && wr_en && (wr_idx != '0)) begin
      regs[wr_idx] <= wr_data;
    end
  end

  // x0 is hardwired
  assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// File: hw/rv_execute.sv
/* combinational ALU, branch compare and target adder
   shift amounts use the low five bits of the second operand */
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
  input  rv_core_pkg::instr_class_e instr_class,
  input  rv_core_pkg::alu_op_e      alu_op,
  input  rv_core_pkg::addr_t        pc,
  input  rv_core_pkg::word_t        rs1_val,
  input  rv_core_pkg::word_t        rs2_val,
  input  rv_core_pkg::word_t        imm,
  output rv_core_pkg::word_t        result,
  output logic                      taken,
  output rv_core_pkg::addr_t        target
);

  rv_core_pkg::word_t op_b;
  rv_core_pkg::word_t alu_out;
  logic               br_eq;
  logic               br_lt;
  logic               br_ltu;
  logic               br_cmp;

  // immediate forms and lui take imm as the second operand
  assign op_b = (instr_class == rv_core_pkg::CLS_ALU_REG) ? rs2_val : imm;

  always_comb begin
    case (alu_op)
      rv_core_pkg::ALU_ADD:    alu_out = rs1_val + op_b;
      rv_core_pkg::ALU_SUB:    alu_out = rs1_val - op_b;
      rv_core_pkg::ALU_AND:    alu_out = rs1_val & op_b;
      rv_core_pkg::ALU_OR:     alu_out = rs1_val | op_b;
      rv_core_pkg::ALU_XOR:    alu_out = rs1_val ^ op_b;
      rv_core_pkg::ALU_SLL:    alu_out = rs1_val << op_b[4:0];
      rv_core_pkg::ALU_SRL:    alu_out = rs1_val >> op_b[4:0];
      rv_core_pkg::ALU_SRA:    alu_out = rv_core_pkg::word_t'($signed(rs1_val) >>> op_b[4:0]);
      rv_core_pkg::ALU_SLT:    alu_out = {31'b0, $signed(rs1_val) < $signed(op_b)};
      rv_core_pkg::ALU_SLTU:   alu_out = {31'b0, rs1_val < op_b};
      rv_core_pkg::ALU_PASS_B: alu_out = op_b;
      default:                 alu_out = '0;
    endcase
  end

  // branches compare the two registers
  assign br_eq  = (rs1_val == rs2_val);
  assign br_lt  = ($signed(rs1_val) < $signed(rs2_val));
  assign br_ltu = (rs1_val < rs2_val);

  // funct3[2:1] picks the compare, funct3[0] inverts it
  always_comb begin
    case (alu_op[2:1])
      2'b00:   br_cmp = br_eq;
      2'b10:   br_cmp = br_lt;
      2'b11:   br_cmp = br_ltu;
      default: br_cmp = 1'b0;
    endcase
  end

  assign target = pc + imm;

  always_comb begin
    result = alu_out;
    taken  = 1'b0;
    case (instr_class)
      rv_core_pkg::CLS_BRANCH: taken = br_cmp ^ alu_op[0];
      rv_core_pkg::CLS_JAL: begin
        result = pc + 32'd4;
        taken  = 1'b1;
      end
      // memory address for the sequencer
      rv_core_pkg::CLS_LOAD,
      rv_core_pkg::CLS_STORE:  result = rs1_val + imm;
      default:                 result = alu_out;
    endcase
  end

endmodule

`default_nettype wire

// File: hw/rv_mem_ctrl.sv
/* word transfers as four byte cycles behind a four-phase req/ack
   read 6 cycles req to ack, write 5; rdy_in low stalls a step */
`timescale 1ns/1ps
`default_nettype none

module rv_mem_ctrl (
  input  logic               clk_in,
  input  logic               rst_n,
  input  logic               rdy_in,
  input  logic               mem_req,
  input  logic               mem_write,
  input  rv_core_pkg::addr_t mem_addr,
  input  rv_core_pkg::word_t mem_wdata,
  output logic               mem_ack,
  output rv_core_pkg::word_t mem_rdata,
  input  rv_core_pkg::byte_t mem_din,
  output rv_core_pkg::byte_t mem_dout,
  output rv_core_pkg::addr_t mem_a,
  output logic               mem_wr
);

  logic               busy;
  logic               wr_mode;
  logic               wr_q;
  logic [1:0]         idx;
  logic [1:0]         idx_next;
  logic               din_vld;
  logic [1:0]         din_idx;
  rv_core_pkg::word_t rdata_q;

  assign idx_next  = idx + 2'd1;
  assign mem_wr    = wr_q & rdy_in;
  assign mem_rdata = rdata_q;

  always_ff @(posedge clk_in or negedge rst_n) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      wr_mode  <= 1'b0;
      wr_q     <= 1'b0;
      idx      <= '0;
      mem_a    <= '0;
      mem_dout <= '0;
      mem_ack  <= 1'b0;
    end else if (rdy_in) begin
      if (!busy) begin
        if (mem_req && !mem_ack) begin
          busy     <= 1'b1;
          wr_mode  <= mem_write;
          wr_q     <= mem_write;
          idx      <= '0;
          mem_a    <= mem_addr;
          mem_dout <= mem_write ? mem_wdata[7:0] : '0;
        end else if (!mem_req) begin
          mem_ack <= 1'b0;
        end
      end else if (idx != 2'd3) begin
        // step to the next byte address
        idx   <= idx_next;
        mem_a <= mem_addr + rv_core_pkg::addr_t'(idx_next);
        if (wr_mode) begin
          mem_dout <= mem_wdata[8*idx_next +: 8];
        end
      end else if (wr_mode || (din_vld && din_idx == 2'd3)) begin
        // last byte written, or last read byte landing now
        busy     <= 1'b0;
        wr_q     <= 1'b0;
        mem_dout <= '0;
        mem_ack  <= 1'b1;
      end
    end
  end

  // tracks which byte is on mem_din, the memory answers even while paused
  always_ff @(posedge clk_in or negedge rst_n) begin
    if (!rst_n) begin
      din_vld <= 1'b0;
      din_idx <= '0;
    end else begin
      din_vld <= busy & ~wr_mode;
      din_idx <= idx;
    end
  end

  // little-endian assembly
  always_ff @(posedge clk_in) begin
    if (din_vld) begin
      rdata_q[8*din_idx +: 8] <= mem_din;
    end
  end

endmodule

`default_nettype wire

// File: hw/rv_sequencer.sv
/* one instruction at a time: fetch, execute, optional memory, result
   pc starts at RESET_PC; rdy_in low holds every step */
`timescale 1ns/1ps
`default_nettype none

module rv_sequencer (
  input  logic                      clk_in,
  input  logic                      rst_n,
  input  logic                      rdy_in,
  output rv_core_pkg::word_t        instr,
  output rv_core_pkg::addr_t        pc,
  input  rv_core_pkg::instr_class_e instr_class,
  input  rv_core_pkg::reg_idx_t     rd,
  input  rv_core_pkg::word_t        rs2_val,
  input  rv_core_pkg::word_t        result,
  input  logic                      taken,
  input  rv_core_pkg::addr_t        target,
  output logic                      wr_en,
  output rv_core_pkg::reg_idx_t     wr_idx,
  output rv_core_pkg::word_t        wr_data,
  output logic                      mem_req,
  output logic                      mem_write,
  output rv_core_pkg::addr_t        mem_addr,
  output rv_core_pkg::word_t        mem_wdata,
  input  logic                      mem_ack,
  input  rv_core_pkg::word_t        mem_rdata
);

  rv_core_pkg::seq_state_e state;
  rv_core_pkg::word_t      res_q;
  rv_core_pkg::addr_t      target_q;
  logic                    taken_q;
  logic                    is_mem;
  logic                    writes_rd;
  logic                    xfer_done;

  assign is_mem    = (instr_class == rv_core_pkg::CLS_LOAD) ||
                     (instr_class == rv_core_pkg::CLS_STORE);
  assign writes_rd = (instr_class != rv_core_pkg::CLS_BRANCH) &&
                     (instr_class != rv_core_pkg::CLS_STORE) &&
                     (instr_class != rv_core_pkg::CLS_NOP);
  assign xfer_done = mem_req && mem_ack;

  assign wr_en   = (state == rv_core_pkg::SEQ_RESULT) && writes_rd;
  assign wr_idx  = rd;
  assign wr_data = res_q;

  // request fields stay stable for the whole state
  assign mem_addr  = (state == rv_core_pkg::SEQ_MEMORY) ? res_q : pc;
  assign mem_write = (state == rv_core_pkg::SEQ_MEMORY) &&
                     (instr_class == rv_core_pkg::CLS_STORE);
  assign mem_wdata = rs2_val;

  always_ff @(posedge clk_in or negedge rst_n) begin
    if (!rst_n) begin
      state   <= rv_core_pkg::SEQ_FETCH;
      pc      <= rv_core_pkg::RESET_PC;
      mem_req <= 1'b0;
      taken_q <= 1'b0;
    end else if (rdy_in) begin
      case (state)
        rv_core_pkg::SEQ_FETCH,
        rv_core_pkg::SEQ_MEMORY: begin
          if (xfer_done) begin
            mem_req <= 1'b0;
            state   <= (state == rv_core_pkg::SEQ_FETCH) ? rv_core_pkg::SEQ_EXECUTE
                                                         : rv_core_pkg::SEQ_RESULT;
          end else if (!mem_req && !mem_ack) begin
            mem_req <= 1'b1;
          end
        end
        rv_core_pkg::SEQ_EXECUTE: begin
          taken_q <= taken;
          state   <= is_mem ? rv_core_pkg::SEQ_MEMORY : rv_core_pkg::SEQ_RESULT;
        end
        default: begin
          pc    <= taken_q ? target_q : pc + 32'd4;
          state <= rv_core_pkg::SEQ_FETCH;
        end
      endcase
    end
  end

  always_ff @(posedge clk_in) begin
    if (rdy_in) begin
      if (state == rv_core_pkg::SEQ_FETCH && xfer_done) begin
        instr <= mem_rdata;
      end
      if (state == rv_core_pkg::SEQ_EXECUTE) begin
        res_q    <= result;
        target_q <= target;
      end
      // load data replaces the address
      if (state == rv_core_pkg::SEQ_MEMORY && xfer_done &&
          instr_class == rv_core_pkg::CLS_LOAD) begin
        res_q <= mem_rdata;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/cpu.sv
/* top of the multi-cycle RV32I subset core on a byte-wide bus
   read data arrives one cycle after the address; rdy_in low pauses the core */
`timescale 1ns/1ps
`default_nettype none

module cpu (
  input  logic               clk_in,
  input  logic               rst_n,
  // pause whole core when low
  input  logic               rdy_in,
  input  rv_core_pkg::byte_t mem_din,
  output rv_core_pkg::byte_t mem_dout,
  output rv_core_pkg::addr_t mem_a,
  // 1 for write
  output logic               mem_wr
);

  rv_core_pkg::word_t        instr;
  rv_core_pkg::addr_t        pc;
  rv_core_pkg::reg_idx_t     rs1;
  rv_core_pkg::reg_idx_t     rs2;
  rv_core_pkg::reg_idx_t     rd;
  rv_core_pkg::word_t        imm;
  rv_core_pkg::alu_op_e      alu_op;
  rv_core_pkg::instr_class_e instr_class;
  rv_core_pkg::word_t        rs1_val;
  rv_core_pkg::word_t        rs2_val;
  rv_core_pkg::word_t        result;
  logic                      taken;
  rv_core_pkg::addr_t        target;
  logic                      wr_en;
  rv_core_pkg::reg_idx_t     wr_idx;
  rv_core_pkg::word_t        wr_data;

  // sequencer to memory controller handshake
  logic                      mem_req;
  logic                      mem_write;
  rv_core_pkg::addr_t        mem_addr;
  rv_core_pkg::word_t        mem_wdata;
  logic                      mem_ack;
  rv_core_pkg::word_t        mem_rdata;

  rv_sequencer sequencer_ (
    .clk_in      (clk_in),
    .rst_n       (rst_n),
    .rdy_in      (rdy_in),
    .instr       (instr),
    .pc          (pc),
    .instr_class (instr_class),
    .rd          (rd),
    .rs2_val     (rs2_val),
    .result      (result),
    .taken       (taken),
    .target      (target),
    .wr_en       (wr_en),
    .wr_idx      (wr_idx),
    .wr_data     (wr_data),
    .mem_req     (mem_req),
    .mem_write   (mem_write),
    .mem_addr    (mem_addr),
    .mem_wdata   (mem_wdata),
    .mem_ack     (mem_ack),
    .mem_rdata   (mem_rdata)
  );

  rv_decode decode_ (
    .instr       (instr),
    .rs1         (rs1),
    .rs2         (rs2),
    .rd          (rd),
    .imm         (imm),
    .alu_op      (alu_op),
    .instr_class (instr_class)
  );

  rv_reg_file reg_file_ (
    .clk_in  (clk_in),
    .rst_n   (rst_n),
    .rdy_in  (rdy_in),
    .rs1     (rs1),
    .rs2     (rs2),
    .rs1_val (rs1_val),
    .rs2_val (rs2_val),
    .wr_en   (wr_en),
    .wr_idx  (wr_idx),
    .wr_data (wr_data)
  );

  rv_execute execute_ (
    .instr_class (instr_class),
    .alu_op      (alu_op),
    .pc          (pc),
    .rs1_val     (rs1_val),
    .rs2_val     (rs2_val),
    .imm         (imm),
    .result      (result),
    .taken       (taken),
    .target      (target)
  );

  rv_mem_ctrl mem_ctrl_ (
    .clk_in    (clk_in),
    .rst_n     (rst_n),
    .rdy_in    (rdy_in),
    .mem_req   (mem_req),
    .mem_write (mem_write),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_ack   (mem_ack),
    .mem_rdata (mem_rdata),
    .mem_din   (mem_din),
    .mem_dout  (mem_dout),
    .mem_a     (mem_a),
    .mem_wr    (mem_wr)
  );

endmodule

`default_nettype wire

// File: test/tb_programs.svh
/* stimulus rows and the program builder, included inside tb_cpu
   programs start at address 0 and end with a store to the halt address */
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

typedef enum int {
  OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU,
  OP_ADDI, OP_ANDI, OP_ORI, OP_XORI, OP_SLLI, OP_SRLI, OP_SRAI, OP_SLTI, OP_SLTIU,
  OP_LUI, OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU, OP_JAL, OP_X0
} op_e;

typedef struct packed {
  op_e         op;
  logic [31:0] a;
  logic [31:0] b;
  logic [19:0] imm;
  logic        rnd;
} row_t;

localparam int NUM_ROWS = 38;

// op, operand a, operand b, immediate, random operands
localparam row_t ROWS [NUM_ROWS] = '{
  '{OP_ADD,   32'h7fff_ffff, 32'h0000_0001, 20'h00000, 1'b0},
  '{OP_SUB,   32'h0000_0005, 32'h0000_0007, 20'h00000, 1'b0},
  '{OP_AND,   32'hf0f0_1234, 32'h0ff0_ff00, 20'h00000, 1'b0},
  '{OP_OR,    32'hf0f0_1234, 32'h0ff0_ff00, 20'h00000, 1'b0},
  '{OP_XOR,   32'hdead_beef, 32'h1234_5678, 20'h00000, 1'b0},
  '{OP_SLL,   32'h8000_0001, 32'h0000_0021, 20'h00000, 1'b0},
  '{OP_SRL,   32'h8000_0000, 32'hffff_ffe4, 20'h00000, 1'b0},
  '{OP_SRA,   32'h8000_0000, 32'h0000_0044, 20'h00000, 1'b0},
  '{OP_SLT,   32'hffff_fffe, 32'h0000_0001, 20'h00000, 1'b0},
  '{OP_SLTU,  32'hffff_fffe, 32'h0000_0001, 20'h00000, 1'b0},
  '{OP_ADDI,  32'h0000_0010, 32'h0000_0000, 20'h00fff, 1'b0},
  '{OP_ANDI,  32'h1234_5678, 32'h0000_0000, 20'h008f0, 1'b0},
  '{OP_ORI,   32'h0000_0000, 32'h0000_0000, 20'h007ff, 1'b0},
  '{OP_XORI,  32'h5555_5555, 32'h0000_0000, 20'h00aaa, 1'b0},
  '{OP_SLLI,  32'h0000_0001, 32'h0000_0000, 20'h0001f, 1'b0},
  '{OP_SRLI,  32'hf000_0000, 32'h0000_0000, 20'h0001c, 1'b0},
  '{OP_SRAI,  32'h8000_0000, 32'h0000_0000, 20'h0001f, 1'b0},
  '{OP_SLTI,  32'hffff_fff0, 32'h0000_0000, 20'h00fff, 1'b0},
  '{OP_SLTIU, 32'h0000_0005, 32'h0000_0000, 20'h00fff, 1'b0},
  '{OP_LUI,   32'h0000_0000, 32'h0000_0000, 20'habcde, 1'b0},
  '{OP_BEQ,   32'h0000_0007, 32'h0000_0007, 20'h00000, 1'b0},
  '{OP_BEQ,   32'h0000_0007, 32'h0000_0008, 20'h00000, 1'b0},
  '{OP_BNE,   32'h0000_0007, 32'h0000_0008, 20'h00000, 1'b0},
  '{OP_BNE,   32'h0000_0007, 32'h0000_0007, 20'h00000, 1'b0},
  '{OP_BLT,   32'hffff_ffff, 32'h0000_0001, 20'h00000, 1'b0},
  '{OP_BLT,   32'h0000_0001, 32'hffff_ffff, 20'h00000, 1'b0},
  '{OP_BGE,   32'h0000_0001, 32'hffff_ffff, 20'h00000, 1'b0},
  '{OP_BGE,   32'hffff_ffff, 32'h0000_0001, 20'h00000, 1'b0},
  '{OP_BLTU,  32'h0000_0001, 32'hffff_ffff, 20'h00000, 1'b0},
  '{OP_BLTU,  32'hffff_ffff, 32'h0000_0001, 20'h00000, 1'b0},
  '{OP_BGEU,  32'hffff_ffff, 32'h0000_0001, 20'h00000, 1'b0},
  '{OP_BGEU,  32'h0000_0001, 32'hffff_ffff, 20'h00000, 1'b0},
  '{OP_JAL,   32'h0000_0000, 32'h0000_0000, 20'h00000, 1'b0},
  '{OP_X0,    32'h0000_1234, 32'h0000_0000, 20'h00055, 1'b0},
  '{OP_ADD,   32'h0000_0000, 32'h0000_0000, 20'h00000, 1'b1},
  '{OP_SRA,   32'h0000_0000, 32'h0000_0000, 20'h00000, 1'b1},
  '{OP_SLT,   32'h0000_0000, 32'h0000_0000, 20'h00000, 1'b1},
  '{OP_SLTU,  32'h0000_0000, 32'h0000_0000, 20'h00000, 1'b1}
};

function automatic logic [2:0] funct3_of(input op_e op);
  case (op)
    OP_SLL, OP_SLLI, OP_BNE:           return 3'b001;
    OP_SLT, OP_SLTI:                   return 3'b010;
    OP_SLTU, OP_SLTIU:                 return 3'b011;
    OP_XOR, OP_XORI, OP_BLT:           return 3'b100;
    OP_SRL, OP_SRA, OP_SRLI, OP_SRAI, OP_BGE: return 3'b101;
    OP_OR, OP_ORI, OP_BLTU:            return 3'b110;
    OP_AND, OP_ANDI, OP_BGEU:          return 3'b111;
    default:                           return 3'b000;
  endcase
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] opc);
  return {imm, rs1, f3, rd, opc};
endfunction

// sw rs2, imm(rs1)
function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1);
  return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
endfunction

task automatic build_program(input op_e op, input logic [19:0] imm);
  logic [31:0] code [$];
  logic [2:0]  f3;
  logic [6:0]  f7;
  logic [11:0] ifield;
  f3 = funct3_of(op);
  f7 = (op == OP_SUB || op == OP_SRA || op == OP_SRAI) ? 7'h20 : 7'h00;
  code.push_back(enc_i(12'h100, 5'd0, 3'b010, 5'd1, 7'b0000011));
  code.push_back(enc_i(12'h104, 5'd0, 3'b010, 5'd2, 7'b0000011));
  if (op <= OP_SLTU) begin
    code.push_back({f7, 5'd2, 5'd1, f3, 5'd3, 7'b0110011});
  end else if (op <= OP_SLTIU) begin
    if (op == OP_SLLI || op == OP_SRLI || op == OP_SRAI) begin
      ifield = {f7, imm[4:0]};
    end else begin
      ifield = imm[11:0];
    end
    code.push_back(enc_i(ifield, 5'd1, f3, 5'd3, 7'b0010011));
  end else if (op == OP_LUI) begin
    code.push_back({imm, 5'd3, 7'b0110111});
  end else if (op <= OP_BGEU) begin
    // offset +8 jumps over the addi that sets x3 to 1
    code.push_back({1'b0, 6'd0, 5'd2, 5'd1, f3, 4'd4, 1'b0, 7'b1100011});
    code.push_back(enc_i(12'd1, 5'd0, 3'b000, 5'd3, 7'b0010011));
  end else if (op == OP_JAL) begin
    code.push_back({1'b0, 10'd4, 1'b0, 8'd0, 5'd3, 7'b1101111});
    code.push_back(enc_i(12'h7ff, 5'd0, 3'b000, 5'd3, 7'b0010011));
  end else begin
    // addi x0 must leave x0 at zero
    code.push_back(enc_i(imm[11:0], 5'd1, 3'b000, 5'd0, 7'b0010011));
  end
  code.push_back(enc_s(12'h108, (op == OP_X0) ? 5'd0 : 5'd3, 5'd0));
  // lui x4 then sw x0 to the halt address
  code.push_back({20'h00030, 5'd4, 7'b0110111});
  code.push_back(enc_s(12'h004, 5'd0, 5'd4));
  foreach (code[i]) begin
    put_word(32'(4 * i), code[i]);
  end
endtask

`endif

// File: test/tb_cpu.sv
/* runs every row twice, first with rdy_in high, then with random pauses
   memory model is 128 KB, so only the low 17 address bits are stored */
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;

  localparam logic [31:0] OPND_A_ADDR = 32'h0000_0100;
  localparam logic [31:0] OPND_B_ADDR = 32'h0000_0104;
  localparam logic [31:0] RESULT_ADDR = 32'h0000_0108;
  localparam logic [31:0] HALT_ADDR   = 32'h0003_0004;
  localparam int          MEM_BYTES   = 131072;
  localparam logic [31:0] SEED        = 32'hc342;
  localparam int          DRIVE_DELAY = 5;

  `include "tb_programs.svh"

  // two runs per row
  localparam int CYCLE_LIMIT = 2 * NUM_ROWS * 400;

  logic               clk_in = 1'b0;
  logic               rst_n;
  logic               rdy_in;
  rv_core_pkg::byte_t mem_din = '0;
  rv_core_pkg::byte_t mem_dout;
  rv_core_pkg::addr_t mem_a;
  logic               mem_wr;

  rv_core_pkg::byte_t mem [MEM_BYTES];
  logic [31:0]        run_a [NUM_ROWS];
  logic [31:0]        run_b [NUM_ROWS];
  int                 halt_count = 0;
  int                 cycles = 0;
  int                 checks = 0;
  int                 errors = 0;

  cpu i_dut (
    .clk_in   (clk_in),
    .rst_n    (rst_n),
    .rdy_in   (rdy_in),
    .mem_din  (mem_din),
    .mem_dout (mem_dout),
    .mem_a    (mem_a),
    .mem_wr   (mem_wr)
  );

  always #50 clk_in = ~clk_in;

  // read data follows the address by one cycle
  always @(posedge clk_in) begin
    rv_core_pkg::byte_t rd_byte;
    rd_byte = mem[mem_a[16:0]];
    if (mem_wr) begin
      mem[mem_a[16:0]] = mem_dout;
      if (mem_a == HALT_ADDR) begin
        halt_count++;
      end
    end
    #(DRIVE_DELAY) mem_din = rd_byte;
  end

  always @(posedge clk_in) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("timeout after %0d cycles without the halt store", CYCLE_LIMIT);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  task automatic put_word(input logic [31:0] addr, input logic [31:0] w);
    for (int k = 0; k < 4; k++) begin
      mem[addr[16:0] + 17'(k)] = w[8*k +: 8];
    end
  endtask

  function automatic logic [31:0] get_word(input logic [31:0] addr);
    return {mem[addr[16:0] + 17'd3], mem[addr[16:0] + 17'd2],
            mem[addr[16:0] + 17'd1], mem[addr[16:0]]};
  endfunction

  // pattern mixes all 17 address bits
  task automatic fill_memory();
    for (int i = 0; i < MEM_BYTES; i++) begin
      mem[17'(i)] = rv_core_pkg::byte_t'(i ^ (i >> 8) ^ (i >> 16));
    end
  endtask

  // RV32I reference results for the stored x3
  function automatic logic [31:0] expected_result(input op_e op, input logic [31:0] a,
                                                  input logic [31:0] b,
                                                  input logic [19:0] imm);
    logic [31:0] ei;
    logic [31:0] y;
    ei = {{20{imm[11]}}, imm[11:0]};
    y  = (op >= OP_ADDI && op <= OP_SLTIU) ? ei : b;
    case (op)
      OP_ADD, OP_ADDI:   return a + y;
      OP_SUB:            return a - y;
      OP_AND, OP_ANDI:   return a & y;
      OP_OR, OP_ORI:     return a | y;
      OP_XOR, OP_XORI:   return a ^ y;
      OP_SLL, OP_SLLI:   return a << y[4:0];
      OP_SRL, OP_SRLI:   return a >> y[4:0];
      OP_SRA, OP_SRAI:   return 32'($signed(a) >>> y[4:0]);
      OP_SLT, OP_SLTI:   return {31'd0, $signed(a) < $signed(y)};
      OP_SLTU, OP_SLTIU: return {31'd0, a < y};
      OP_LUI:            return {imm, 12'd0};
      // taken branch leaves x3 at 0
      OP_BEQ:            return {31'd0, a != b};
      OP_BNE:            return {31'd0, a == b};
      OP_BLT:            return {31'd0, !($signed(a) < $signed(b))};
      OP_BGE:            return {31'd0, $signed(a) < $signed(b)};
      OP_BLTU:           return {31'd0, !(a < b)};
      OP_BGEU:           return {31'd0, a < b};
      // jal sits at address 8
      OP_JAL:            return 32'd12;
      default:           return 32'd0;
    endcase
  endfunction

  task automatic run_row(input int r, input logic paused);
    logic [31:0] got;
    logic [31:0] want;
    int          halts_before;
    rst_n  = 1'b0;
    rdy_in = 1'b1;
    fill_memory();
    put_word(OPND_A_ADDR, run_a[r]);
    put_word(OPND_B_ADDR, run_b[r]);
    build_program(ROWS[r].op, ROWS[r].imm);
    repeat (4) @(posedge clk_in);
    #(DRIVE_DELAY);
    rst_n = 1'b1;
    #1;
    checks++;
    if (mem_a !== 32'h0 || mem_wr !== 1'b0) begin
      $display("FAIL t=%0t mem_a/mem_wr after reset: got %h/%b expected 00000000/0",
               $time, mem_a, mem_wr);
      errors++;
    end
    halts_before = halt_count;
    while (halt_count == halts_before) begin
      @(posedge clk_in);
      #(DRIVE_DELAY);
      rdy_in = paused ? (($urandom % 4) != 0) : 1'b1;
      #1;
      checks++;
      if (mem_wr && !rdy_in) begin
        $display("FAIL t=%0t mem_wr: got 1 expected 0 while rdy_in is low", $time);
        errors++;
      end
    end
    got  = get_word(RESULT_ADDR);
    want = expected_result(ROWS[r].op, run_a[r], run_b[r], ROWS[r].imm);
    checks++;
    if (got !== want) begin
      $display("FAIL t=%0t row %0d paused %0d mem[0x108]: got %h expected %h",
               $time, r, paused, got, want);
      errors++;
    end
  endtask

  initial begin
    rst_n  = 1'b0;
    rdy_in = 1'b1;
    void'($urandom(SEED));
    // random operands drawn once so both runs of a row match
    for (int r = 0; r < NUM_ROWS; r++) begin
      run_a[r] = ROWS[r].rnd ? $urandom : ROWS[r].a;
      run_b[r] = ROWS[r].rnd ? $urandom : ROWS[r].b;
    end
    for (int pass = 0; pass < 2; pass++) begin
      for (int r = 0; r < NUM_ROWS; r++) begin
        run_row(r, pass == 1);
      end
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: rv32_byte_core.f
+incdir+test
hw/rv_core_pkg.sv
hw/rv_decode.sv
hw/rv_reg_file.sv
hw/rv_execute.sv
hw/rv_mem_ctrl.sv
hw/rv_sequencer.sv
hw/cpu.sv
test/tb_cpu.sv

// File: Makefile
# Verilator build and run of tb_cpu
SRCS := $(wildcard hw/*.sv) $(wildcard test/*.sv) $(wildcard test/*.svh)

.PHONY: all run clean

all: run

obj_dir/Vtb_cpu: rv32_byte_core.f $(SRCS)
	verilator --binary --timing --top-module tb_cpu -f rv32_byte_core.f -o Vtb_cpu

# the log decides pass or fail
run: obj_dir/Vtb_cpu
	./obj_dir/Vtb_cpu > sim.log 2>&1 || true
	cat sim.log
	grep -qF '*** TEST PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log
